/* src/tile_pkg.sv */
`default_nettype none

package tile_pkg;

    localparam int TILES_PER_LINE = 33;  // 32 visible plus one for fine scroll
    localparam int LINE_W         = 256;

    // host write into the tile map, addr is row*32+col
    typedef struct packed {
        logic        en;
        logic [9:0]  addr;
        logic [15:0] data;    // attr in high byte, code in low byte
    } scan_wr_t;

    // host write into tile graphics
    typedef struct packed {
        logic        en;
        logic [12:0] addr;
        logic [15:0] data;
    } gfx_wr_t;

    typedef struct packed {
        logic       bank;     // code bit 8
        logic       spare6;
        logic       vflip;
        logic       hflip;
        logic       spare3;
        logic [2:0] pal;
    } tile_attr_t;

    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] color;
    } line_pix_t;

    typedef struct packed {
        logic       en;
        logic [8:0] x;        // values of LINE_W and up fall off the line
        line_pix_t  pix;
    } line_wr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SCAN,
        ST_ATTR,
        ST_FETCH,
        ST_DUMP,
        ST_NEXT
    } render_st_e;

endpackage

`default_nettype wire

/* src/tile_scan_ram.sv */
`default_nettype none

// 32x32 tile map, one word per map cell
module tile_scan_ram (
    input  wire                 clk,
    input  wire                 rst,
    input  wire tile_pkg::scan_wr_t scan_wr,
    input  wire  [9:0]          rd_addr,
    output logic [15:0]         rd_data
);

    logic [15:0] mem [0:1023];

    // host side
    always_ff @(posedge clk) begin
        if (scan_wr.en) begin
            mem[scan_wr.addr] <= scan_wr.data;
        end
    end

    // data shows up the cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* src/tile_gfx_mem.sv */
`default_nettype none

// tile graphics, 4 pixels per word
module tile_gfx_mem (
    input  wire                clk,
    input  wire                rst,
    input  wire tile_pkg::gfx_wr_t gfx_wr,
    input  wire                rom_cs,
    input  wire  [12:0]        rom_addr,
    output logic               rom_ok,
    output logic [15:0]        rom_data
);

    logic [15:0] mem [0:8191];
    logic [15:0] s1_data;
    logic        s1_vld;
    logic        issued;    // request already taken, wait for cs to drop

    wire stall = gfx_wr.en;    // host write owns the array this cycle
    wire take  = rom_cs && !issued && !stall;

    always_ff @(posedge clk) begin
        if (gfx_wr.en) begin
            mem[gfx_wr.addr] <= gfx_wr.data;
        end
    end

    // stage 1 array read
    always_ff @(posedge clk) begin
        if (take) begin
            s1_data <= mem[rom_addr];
        end
    end

    // stage 2 output word
    always_ff @(posedge clk) begin
        if (s1_vld && !stall) begin
            rom_data <= s1_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
            rom_ok <= 1'b0;
            issued <= 1'b0;
        end else begin
            rom_ok <= 1'b0;
            if (!rom_cs) begin
                issued <= 1'b0;
            end
            if (!stall) begin
                rom_ok <= s1_vld;
                s1_vld <= take;
                if (take) begin
                    issued <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/tile_line_render.sv */
`default_nettype none

// builds one line of tiles into the back half of the line buffer
module tile_line_render (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  hs,
    input  wire  [7:0]           vrender,
    input  wire  [7:0]           hscroll,
    input  wire  [7:0]           vscroll,
    input  wire  [15:0]          scan_data,
    input  wire                  rom_ok,
    input  wire  [15:0]          rom_data,
    output logic                 done,
    output logic                 bank,
    output logic [9:0]           scan_addr,
    output logic                 rom_cs,
    output logic [12:0]          rom_addr,
    output tile_pkg::line_wr_t   line_wr
);

    tile_pkg::render_st_e st;
    tile_pkg::tile_attr_t attr;

    logic        hs_l;
    logic [7:0]  vn;          // map row in 7:3, tile row in 2:0
    logic [4:0]  col;
    logic [5:0]  tile_cnt;
    logic [7:0]  code;
    logic        half;        // which word of the tile row
    logic [1:0]  dump_cnt;
    logic [15:0] pix_data;
    logic [8:0]  x;

    wire       hs_rise   = hs && !hs_l;
    wire       last_tile = tile_cnt == 6'(tile_pkg::TILES_PER_LINE - 1);
    wire [3:0] color     = attr.hflip ? pix_data[3:0] : pix_data[15:12];

    assign scan_addr = {vn[7:3], col};
    // code, tile row, half
    assign rom_addr  = {attr.bank, code, vn[2:0] ^ {3{attr.vflip}}, half ^ attr.hflip};

    // control and line buffer writes
    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= tile_pkg::ST_IDLE;
            done    <= 1'b1;
            bank    <= 1'b0;
            rom_cs  <= 1'b0;
            hs_l    <= 1'b0;
            line_wr <= '0;
        end else begin
            hs_l       <= hs;
            line_wr.en <= 1'b0;
            if (hs_rise) begin
                bank   <= ~bank;    // swap front and back halves
                done   <= 1'b0;
                rom_cs <= 1'b0;
                st     <= tile_pkg::ST_SCAN;
            end else begin
                case (st)
                    tile_pkg::ST_SCAN: begin
                        st <= tile_pkg::ST_ATTR;    // map address out this cycle
                    end
                    tile_pkg::ST_ATTR: begin
                        rom_cs <= 1'b1;
                        st     <= tile_pkg::ST_FETCH;
                    end
                    tile_pkg::ST_FETCH: begin
                        if (rom_ok) begin
                            rom_cs <= 1'b0;
                            st     <= tile_pkg::ST_DUMP;
                        end
                    end
                    tile_pkg::ST_DUMP: begin
                        line_wr.en  <= 1'b1;
                        line_wr.x   <= x;
                        line_wr.pix <= '{pal: attr.pal, color: color};
                        if (dump_cnt == 2'd3) begin
                            if (!half) begin
                                rom_cs <= 1'b1;    // second word of this row
                                st     <= tile_pkg::ST_FETCH;
                            end else if (last_tile) begin
                                st <= tile_pkg::ST_NEXT;
                            end else begin
                                st <= tile_pkg::ST_SCAN;
                            end
                        end
                    end
                    tile_pkg::ST_NEXT: begin
                        done <= 1'b1;
                        st   <= tile_pkg::ST_IDLE;
                    end
                    default: begin
                        st <= tile_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // tile position and pixel data
    always_ff @(posedge clk) begin
        if (hs_rise) begin
            vn       <= vrender + vscroll;
            col      <= hscroll[7:3];
            x        <= 9'd0 - {6'd0, hscroll[2:0]};   // fine scroll starts off screen
            tile_cnt <= '0;
        end else begin
            case (st)
                tile_pkg::ST_ATTR: begin
                    attr <= tile_pkg::tile_attr_t'(scan_data[15:8]);
                    code <= scan_data[7:0];
                    half <= 1'b0;
                end
                tile_pkg::ST_FETCH: begin
                    if (rom_ok) begin
                        pix_data <= rom_data;
                        dump_cnt <= 2'd0;
                    end
                end
                tile_pkg::ST_DUMP: begin
                    pix_data <= attr.hflip ? pix_data >> 4 : pix_data << 4;
                    x        <= x + 9'd1;
                    dump_cnt <= dump_cnt + 2'd1;
                    if (dump_cnt == 2'd3) begin
                        if (half) begin
                            col      <= col + 5'd1;    // wraps around the map
                            tile_cnt <= tile_cnt + 6'd1;
                        end
                        half <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tile_line_buf.sv */
`default_nettype none

// two line halves, renderer fills one while video reads the other
module tile_line_buf (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   bank,
    input  wire tile_pkg::line_wr_t line_wr,
    input  wire  [7:0]            hdump,
    output tile_pkg::line_pix_t   pixel
);

    tile_pkg::line_pix_t mem [0:1][0:255];

    logic [1:0] filled;    // half has been written since reset

    wire wr_ok = line_wr.en && (line_wr.x < 9'(tile_pkg::LINE_W));
    wire rd_bank = ~bank;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[bank][line_wr.x[7:0]] <= line_wr.pix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            filled <= '0;
        end else if (wr_ok) begin
            filled[bank] <= 1'b1;
        end
    end

    // one cycle from hdump to pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel <= '0;
        end else if (filled[rd_bank]) begin
            pixel <= mem[rd_bank][hdump];
        end else begin
            pixel <= '0;   // blank until a line has been drawn
        end
    end

endmodule

`default_nettype wire

/* src/tile_video_top.sv */
`default_nettype none

module tile_video_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     hs,
    input  wire  [7:0]              vrender,
    input  wire  [7:0]              hscroll,
    input  wire  [7:0]              vscroll,
    input  wire tile_pkg::scan_wr_t scan_wr,
    input  wire tile_pkg::gfx_wr_t  gfx_wr,
    input  wire  [7:0]              hdump,
    output tile_pkg::line_pix_t     pixel,
    output logic                    done
);

    logic [9:0]         scan_addr;
    logic [15:0]        scan_data;
    logic               rom_cs;
    logic [12:0]        rom_addr;
    logic               rom_ok;
    logic [15:0]        rom_data;
    logic               bank;
    tile_pkg::line_wr_t line_wr;

    tile_scan_ram u_scan (
        .clk     (clk),
        .rst     (rst),
        .scan_wr (scan_wr),
        .rd_addr (scan_addr),
        .rd_data (scan_data)
    );

    tile_gfx_mem u_gfx (
        .clk      (clk),
        .rst      (rst),
        .gfx_wr   (gfx_wr),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

    tile_line_render u_render (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .vrender   (vrender),
        .hscroll   (hscroll),
        .vscroll   (vscroll),
        .scan_data (scan_data),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .done      (done),
        .bank      (bank),
        .scan_addr (scan_addr),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .line_wr   (line_wr)
    );

    tile_line_buf u_buf (
        .clk     (clk),
        .rst     (rst),
        .bank    (bank),
        .line_wr (line_wr),
        .hdump   (hdump),
        .pixel   (pixel)
    );

endmodule

`default_nettype wire

/* bench/tb_tile_video.sv */
`default_nettype none

module tb_tile_video;
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk = 1'b0;
    logic                rst;
    logic                hs;
    logic [7:0]          vrender;
    logic [7:0]          hscroll;
    logic [7:0]          vscroll;
    logic [7:0]          hdump;
    tile_pkg::scan_wr_t  scan_wr;
    tile_pkg::gfx_wr_t   gfx_wr;
    tile_pkg::line_pix_t pixel;
    logic                done;

    logic [15:0]         scan_img [0:1023];    // mirror of the tile map
    logic [15:0]         gfx_img [0:8191];     // mirror of graphics memory
    tile_pkg::line_pix_t exp_line [0:255];

    integer seed = 32'h16be;
    integer errors = 0;
    integer checks = 0;
    integer tests_run = 0;
    integer tests_failed = 0;
    integer test_err0 = 0;
    logic   timed_out = 1'b0;

    always #5 clk = ~clk;

    tile_video_top DUT (
        .clk     (clk),
        .rst     (rst),
        .hs      (hs),
        .vrender (vrender),
        .hscroll (hscroll),
        .vscroll (vscroll),
        .scan_wr (scan_wr),
        .gfx_wr  (gfx_wr),
        .hdump   (hdump),
        .pixel   (pixel),
        .done    (done)
    );

    // ends the run when a wait gives up
    initial begin
        wait (timed_out);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic load_gfx();
        int a;
        for (a = 0; a < 8192; a++) begin
            @(negedge clk);
            gfx_wr.en   = 1'b1;
            gfx_wr.addr = 13'(a);
            gfx_wr.data = 16'($random(seed));
            gfx_img[a]  = gfx_wr.data;
        end
        @(negedge clk);
        gfx_wr.en = 1'b0;
    endtask

    task automatic load_map(input logic flips);
        int          a;
        logic [15:0] word;
        for (a = 0; a < 1024; a++) begin
            word = 16'($random(seed));
            if (!flips) begin
                word[13:12] = 2'b00;    // vflip and hflip off
            end
            @(negedge clk);
            scan_wr.en   = 1'b1;
            scan_wr.addr = 10'(a);
            scan_wr.data = word;
            scan_img[a]  = word;
        end
        @(negedge clk);
        scan_wr.en = 1'b0;
    endtask

    // reference line: screen pixel sx shows map pixel sx + hscroll
    task automatic build_expected(input logic [7:0] v, input logic [7:0] h,
                                  input logic [7:0] vs);
        int                   sx;
        logic [7:0]           vn;
        logic [7:0]           mx;
        logic [15:0]          entry;
        tile_pkg::tile_attr_t at;
        logic [2:0]           row;
        logic [2:0]           p;
        logic [15:0]          word;
        vn = v + vs;
        for (sx = 0; sx < 256; sx++) begin
            mx    = 8'(sx) + h;    // 32 tiles wrap at 256 pixels
            entry = scan_img[{vn[7:3], mx[7:3]}];
            at    = tile_pkg::tile_attr_t'(entry[15:8]);
            row   = at.vflip ? ~vn[2:0] : vn[2:0];
            p     = at.hflip ? ~mx[2:0] : mx[2:0];    // pixel within the source row
            word  = gfx_img[{at.bank, entry[7:0], row, p[2]}];
            exp_line[sx].pal   = at.pal;
            exp_line[sx].color = 4'(word >> (12 - 4 * int'(p[1:0])));
        end
    endtask

    task automatic start_line(input logic [7:0] v, input logic [7:0] h, input logic [7:0] vs);
        @(negedge clk);
        vrender = v;
        hscroll = h;
        vscroll = vs;
        hs      = 1'b1;
        @(negedge clk);
        hs = 1'b0;
    endtask

    // optional host writes go to tile rows the current line never touches
    task automatic wait_done(input int host_writes, input logic [2:0] busy_row,
                             output int cycles);
        int         n;
        int         w;
        logic [2:0] r;
        n = 0;
        w = 0;
        r = busy_row + 3'd1;
        if (r == ~busy_row) begin
            r = busy_row + 3'd2;
        end
        while (done !== 1'b1 && n < 2000) begin
            @(negedge clk);
            n++;
            gfx_wr.en = 1'b0;
            if (w < host_writes && n[0]) begin
                gfx_wr.en   = 1'b1;
                gfx_wr.addr = {9'($random(seed)), r, 1'($random(seed))};
                gfx_wr.data = 16'($random(seed));
                gfx_img[gfx_wr.addr] = gfx_wr.data;
                w++;
            end
        end
        @(negedge clk);
        gfx_wr.en = 1'b0;
        if (done !== 1'b1) begin
            $display("timeout: done stayed low for 2000 cycles at %0t", $time);
            timed_out = 1'b1;
            forever @(negedge clk);
        end
        cycles = n;
    endtask

    // pixel is registered, so sample one cycle after hdump
    task automatic check_front();
        int x;
        for (x = 0; x < 256; x++) begin
            @(negedge clk);
            hdump = 8'(x);
            @(negedge clk);
            checks++;
            assert (pixel === exp_line[x]) else begin
                errors++;
                $display("ERROR %0t pixel[%0d] expected %h got %h",
                         $time, x, exp_line[x], pixel);
            end
        end
    endtask

    task automatic render_and_check(input logic [7:0] v, input logic [7:0] h,
                                    input logic [7:0] vs, input int host_writes,
                                    output int cycles);
        logic [2:0] trow;
        int         spare;
        build_expected(v, h, vs);
        trow = 3'(v + vs);
        start_line(v, h, vs);
        wait_done(host_writes, trow, cycles);
        start_line(v + 8'd1, h, vs);    // next line fills the back half meanwhile
        check_front();
        wait_done(0, trow, spare);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin
        int         i;
        int         cyc;
        int         quiet_cycles;
        logic [7:0] h;
        rst     = 1'b1;
        hs      = 1'b0;
        vrender = '0;
        hscroll = '0;
        vscroll = '0;
        hdump   = '0;
        scan_wr = '0;
        gfx_wr  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        assert (done === 1'b1) else begin
            errors++;
            $display("ERROR %0t done expected 1 got %b", $time, done);
        end
        for (i = 0; i < 256; i++) begin
            exp_line[i] = '0;
        end
        check_front();
        end_test("reset state");

        load_gfx();
        load_map(1'b0);
        render_and_check(8'd37, 8'd0, 8'd0, 0, cyc);
        render_and_check(8'd200, 8'd0, 8'd0, 0, cyc);
        end_test("zero scroll");

        for (i = 0; i < 4; i++) begin
            h      = 8'($random(seed));
            h[2:0] = 3'(1 + ($unsigned($random(seed)) % 7));    // fine scroll 1..7
            render_and_check(8'($random(seed)), h, 8'($random(seed)), 0, cyc);
        end
        end_test("scroll");

        load_map(1'b1);
        render_and_check(8'd5, 8'd0, 8'd0, 0, cyc);
        render_and_check(8'($random(seed)), 8'($random(seed)), 8'($random(seed)), 0, cyc);
        end_test("flips");

        render_and_check(8'd90, 8'd13, 8'd7, 0, quiet_cycles);
        render_and_check(8'd90, 8'd13, 8'd7, 64, cyc);
        assert (cyc > quiet_cycles) else begin
            errors++;
            $display("ERROR %0t render_cycles expected more than %0d got %0d",
                     $time, quiet_cycles, cyc);
        end
        end_test("host writes");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/tile_pkg.sv
src/tile_scan_ram.sv
src/tile_gfx_mem.sv
src/tile_line_render.sv
src/tile_line_buf.sv
src/tile_video_top.sv
bench/tb_tile_video.sv

/* Makefile */
# verilator build and run of the tile line renderer testbench

SIM := obj_dir/Vtb_tile_video

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) | tee run.log
	grep -q "TESTS PASSED" run.log

$(SIM): all.f $(wildcard src/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module tb_tile_video -o Vtb_tile_video

lint:
	verilator --lint-only --timing -f all.f --top-module tile_video_top

clean:
	rm -rf obj_dir run.log
